//--- hw/dualIssue_settings.svh
`ifndef DUALISSUE_SETTINGS_SVH
`define DUALISSUE_SETTINGS_SVH

// Datapath word width
`define XLEN 32

// Register file geometry
`define REG_ADDR_W 5
`define NUM_REGS 32

// Immediate field carried with each slot
`define IMM_W 12

`endif

//--- hw/dualIssuePkg.sv
`default_nettype none

`include "dualIssue_settings.svh"

package dualIssuePkg;

    // Decoded opcodes
    // opMul is only valid in slot B
    typedef enum logic [3:0] {
        opAdd  = 4'd0,
        opSub  = 4'd1,
        opAnd  = 4'd2,
        opOr   = 4'd3,
        opXor  = 4'd4,
        opSll  = 4'd5,
        opSrl  = 4'd6,
        opAddi = 4'd7,   // Second operand is the immediate
        opMul  = 4'd8
    } aluOp;

    typedef enum logic {
        resAlu = 1'b0,   // Write back the ALU result
        resMul = 1'b1    // Write back the product
    } resultSrc;

    typedef logic [`XLEN-1:0] dataWord;
    typedef logic [`REG_ADDR_W-1:0] regAddr;

endpackage

`default_nettype wire

//--- hw/regFile.sv
`timescale 1ns/1ns
`default_nettype none

`include "dualIssue_settings.svh"

module regFile import dualIssuePkg::*; (
    input  wire logic clk,
    input  wire logic arstN,
    input  wire regAddr raddr0,
    input  wire regAddr raddr1,
    input  wire regAddr raddr2,
    input  wire regAddr raddr3,
    output dataWord rdata0,
    output dataWord rdata1,
    output dataWord rdata2,
    output dataWord rdata3,
    input  wire logic weA,
    input  wire regAddr waddrA,
    input  wire dataWord wdataA,
    input  wire logic weB,
    input  wire regAddr waddrB,
    input  wire dataWord wdataB
);

    dataWord regs [`NUM_REGS];

    assign rdata0 = regs[raddr0];
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];
    assign rdata3 = regs[raddr3];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (weA) regs[waddrA] <= wdataA;
            if (weB) regs[waddrB] <= wdataB;   // B is written last and wins a collision
        end
    end

endmodule

`default_nettype wire

//--- hw/exLatch.sv
`timescale 1ns/1ns
`default_nettype none

`include "dualIssue_settings.svh"

module exLatch import dualIssuePkg::*; (
    input  wire logic clk,
    input  wire logic arstN,
    input  wire logic issueValid,
    input  wire aluOp opA,
    input  wire regAddr rs1A,
    input  wire regAddr rs2A,
    input  wire regAddr rdA,
    input  wire logic weA,
    input  wire logic [`IMM_W-1:0] immA,
    input  wire aluOp opB,
    input  wire regAddr rs1B,
    input  wire regAddr rs2B,
    input  wire regAddr rdB,
    input  wire logic weB,
    input  wire logic [`IMM_W-1:0] immB,
    output aluOp exOpA,
    output regAddr exRs1A,
    output regAddr exRs2A,
    output regAddr exRdA,
    output logic exWeA,
    output logic [`IMM_W-1:0] exImmA,
    output aluOp exOpB,
    output regAddr exRs1B,
    output regAddr exRs2B,
    output regAddr exRdB,
    output logic exWeB,
    output logic [`IMM_W-1:0] exImmB,
    output resultSrc exSrcB
);

    // A write to x0 is dropped here so x0 stays zero
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exWeA  <= 1'b0;
            exWeB  <= 1'b0;
            exSrcB <= resAlu;
        end else begin
            exWeA  <= issueValid && weA && (rdA != '0);
            exWeB  <= issueValid && weB && (rdB != '0);
            exSrcB <= (opB == opMul) ? resMul : resAlu;   // Mux select for WB
        end
    end

    always_ff @(posedge clk) begin
        exOpA  <= opA;
        exRs1A <= rs1A;
        exRs2A <= rs2A;
        exRdA  <= rdA;
        exImmA <= immA;
        exOpB  <= opB;
        exRs1B <= rs1B;
        exRs2B <= rs2B;
        exRdB  <= rdB;
        exImmB <= immB;
    end

endmodule

`default_nettype wire

//--- hw/forwardUnit.sv
`timescale 1ns/1ns
`default_nettype none

module forwardUnit import dualIssuePkg::*; (
    input  wire regAddr exRs1A,
    input  wire regAddr exRs2A,
    input  wire regAddr exRs1B,
    input  wire regAddr exRs2B,
    input  wire dataWord rfData1A,
    input  wire dataWord rfData2A,
    input  wire dataWord rfData1B,
    input  wire dataWord rfData2B,
    input  wire regAddr memRdA,
    input  wire regAddr memRdB,
    input  wire logic memWeA,
    input  wire logic memWeB,
    input  wire resultSrc memSrcB,
    input  wire dataWord memAluA,
    input  wire dataWord memAluB,
    input  wire regAddr wbRdA,
    input  wire regAddr wbRdB,
    input  wire logic wbWeA,
    input  wire logic wbWeB,
    input  wire dataWord wbDataA,
    input  wire dataWord wbDataB,
    output dataWord opnd1A,
    output dataWord opnd2A,
    output dataWord opnd1B,
    output dataWord opnd2B
);

    // Younger slot first, nearer stage first.
    // The MEM product is still being formed, so MEM B only bypasses ALU results.
    // Write flags are already low for x0, so no zero-address test is needed.
    function automatic dataWord pickOperand(input regAddr addr, input dataWord rfData);
        dataWord val;
        if (memWeB && (memSrcB == resAlu) && (addr == memRdB)) begin
            val = memAluB;
        end else if (memWeA && (addr == memRdA)) begin
            val = memAluA;
        end else if (wbWeB && (addr == wbRdB)) begin
            val = wbDataB;   // May carry a product
        end else if (wbWeA && (addr == wbRdA)) begin
            val = wbDataA;
        end else begin
            val = rfData;
        end
        return val;
    endfunction

    always_comb begin
        opnd1A = pickOperand(exRs1A, rfData1A);
        opnd2A = pickOperand(exRs2A, rfData2A);
        opnd1B = pickOperand(exRs1B, rfData1B);
        opnd2B = pickOperand(exRs2B, rfData2B);
    end

endmodule

`default_nettype wire

//--- hw/aluUnit.sv
`timescale 1ns/1ns
`default_nettype none

`include "dualIssue_settings.svh"

module aluUnit import dualIssuePkg::*; (
    input  wire aluOp op,
    input  wire dataWord opnd1,
    input  wire dataWord opnd2,
    input  wire logic [`IMM_W-1:0] imm,
    output dataWord result
);

    dataWord immExt;

    assign immExt = {{(`XLEN-`IMM_W){imm[`IMM_W-1]}}, imm};   // Sign extend

    always_comb begin
        case (op)
            opAdd:   result = opnd1 + opnd2;
            opSub:   result = opnd1 - opnd2;
            opAnd:   result = opnd1 & opnd2;
            opOr:    result = opnd1 | opnd2;
            opXor:   result = opnd1 ^ opnd2;
            opSll:   result = opnd1 << opnd2[4:0];
            opSrl:   result = opnd1 >> opnd2[4:0];   // Logical shift
            opAddi:  result = opnd1 + immExt;
            opMul:   result = '0;   // Product comes from MEM
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/memStage.sv
`timescale 1ns/1ns
`default_nettype none

module memStage import dualIssuePkg::*; (
    input  wire logic clk,
    input  wire logic arstN,
    input  wire regAddr exRdA,
    input  wire regAddr exRdB,
    input  wire logic exWeA,
    input  wire logic exWeB,
    input  wire resultSrc exSrcB,
    input  wire dataWord aluA,
    input  wire dataWord aluB,
    input  wire dataWord opnd1B,
    input  wire dataWord opnd2B,
    output regAddr memRdA,
    output regAddr memRdB,
    output logic memWeA,
    output logic memWeB,
    output resultSrc memSrcB,
    output dataWord memAluA,
    output dataWord memAluB,
    output dataWord memProdB
);

    dataWord mulOp1;
    dataWord mulOp2;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memWeA  <= 1'b0;
            memWeB  <= 1'b0;
            memSrcB <= resAlu;
        end else begin
            memWeA  <= exWeA;
            memWeB  <= exWeB;
            memSrcB <= exSrcB;
        end
    end

    always_ff @(posedge clk) begin
        memRdA  <= exRdA;
        memRdB  <= exRdB;
        memAluA <= aluA;
        memAluB <= aluB;
        mulOp1  <= opnd1B;   // Forwarded slot B operands
        mulOp2  <= opnd2B;
    end

    // Low word of the product
    assign memProdB = mulOp1 * mulOp2;

endmodule

`default_nettype wire

//--- hw/wbStage.sv
`timescale 1ns/1ns
`default_nettype none

module wbStage import dualIssuePkg::*; (
    input  wire logic clk,
    input  wire logic arstN,
    input  wire regAddr memRdA,
    input  wire regAddr memRdB,
    input  wire logic memWeA,
    input  wire logic memWeB,
    input  wire resultSrc memSrcB,
    input  wire dataWord memAluA,
    input  wire dataWord memAluB,
    input  wire dataWord memProdB,
    output regAddr wbRdA,
    output regAddr wbRdB,
    output logic wbWeA,
    output logic wbWeB,
    output dataWord wbDataA,
    output dataWord wbDataB
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbWeA <= 1'b0;
            wbWeB <= 1'b0;
        end else begin
            wbWeA <= memWeA;
            wbWeB <= memWeB;
        end
    end

    always_ff @(posedge clk) begin
        wbRdA   <= memRdA;
        wbRdB   <= memRdB;
        wbDataA <= memAluA;
        wbDataB <= (memSrcB == resMul) ? memProdB : memAluB;   // Result select
    end

endmodule

`default_nettype wire

//--- hw/dualIssueExec.sv
`timescale 1ns/1ns
`default_nettype none

`include "dualIssue_settings.svh"

module dualIssueExec import dualIssuePkg::*; (
    input  wire logic clk,
    input  wire logic arstN,
    input  wire logic issueValid,
    input  wire aluOp opA,
    input  wire regAddr rs1A,
    input  wire regAddr rs2A,
    input  wire regAddr rdA,
    input  wire logic weA,
    input  wire logic [`IMM_W-1:0] immA,
    input  wire aluOp opB,
    input  wire regAddr rs1B,
    input  wire regAddr rs2B,
    input  wire regAddr rdB,
    input  wire logic weB,
    input  wire logic [`IMM_W-1:0] immB,
    output logic wbWeA,
    output regAddr wbAddrA,
    output dataWord wbDataA,
    output logic wbWeB,
    output regAddr wbAddrB,
    output dataWord wbDataB
);

    aluOp exOpA, exOpB;
    regAddr exRs1A, exRs2A, exRdA;
    regAddr exRs1B, exRs2B, exRdB;
    logic exWeA, exWeB;
    logic [`IMM_W-1:0] exImmA, exImmB;
    resultSrc exSrcB;

    dataWord rfData1A, rfData2A, rfData1B, rfData2B;
    dataWord opnd1A, opnd2A, opnd1B, opnd2B;
    dataWord aluA, aluB;

    regAddr memRdA, memRdB;
    logic memWeA, memWeB;
    resultSrc memSrcB;
    dataWord memAluA, memAluB, memProdB;

    exLatch i_exLatch (
        .clk(clk), .arstN(arstN), .issueValid(issueValid),
        .opA(opA), .rs1A(rs1A), .rs2A(rs2A), .rdA(rdA), .weA(weA), .immA(immA),
        .opB(opB), .rs1B(rs1B), .rs2B(rs2B), .rdB(rdB), .weB(weB), .immB(immB),
        .exOpA(exOpA), .exRs1A(exRs1A), .exRs2A(exRs2A), .exRdA(exRdA),
        .exWeA(exWeA), .exImmA(exImmA),
        .exOpB(exOpB), .exRs1B(exRs1B), .exRs2B(exRs2B), .exRdB(exRdB),
        .exWeB(exWeB), .exImmB(exImmB), .exSrcB(exSrcB)
    );

    // Write ports are driven from the WB stage
    regFile i_regFile (
        .clk(clk), .arstN(arstN),
        .raddr0(exRs1A), .raddr1(exRs2A), .raddr2(exRs1B), .raddr3(exRs2B),
        .rdata0(rfData1A), .rdata1(rfData2A), .rdata2(rfData1B), .rdata3(rfData2B),
        .weA(wbWeA), .waddrA(wbAddrA), .wdataA(wbDataA),
        .weB(wbWeB), .waddrB(wbAddrB), .wdataB(wbDataB)
    );

    forwardUnit i_forwardUnit (
        .exRs1A(exRs1A), .exRs2A(exRs2A), .exRs1B(exRs1B), .exRs2B(exRs2B),
        .rfData1A(rfData1A), .rfData2A(rfData2A),
        .rfData1B(rfData1B), .rfData2B(rfData2B),
        .memRdA(memRdA), .memRdB(memRdB), .memWeA(memWeA), .memWeB(memWeB),
        .memSrcB(memSrcB), .memAluA(memAluA), .memAluB(memAluB),
        .wbRdA(wbAddrA), .wbRdB(wbAddrB), .wbWeA(wbWeA), .wbWeB(wbWeB),
        .wbDataA(wbDataA), .wbDataB(wbDataB),
        .opnd1A(opnd1A), .opnd2A(opnd2A), .opnd1B(opnd1B), .opnd2B(opnd2B)
    );

    aluUnit i_aluA (
        .op(exOpA), .opnd1(opnd1A), .opnd2(opnd2A), .imm(exImmA), .result(aluA)
    );

    aluUnit i_aluB (
        .op(exOpB), .opnd1(opnd1B), .opnd2(opnd2B), .imm(exImmB), .result(aluB)
    );

    memStage i_memStage (
        .clk(clk), .arstN(arstN),
        .exRdA(exRdA), .exRdB(exRdB), .exWeA(exWeA), .exWeB(exWeB), .exSrcB(exSrcB),
        .aluA(aluA), .aluB(aluB), .opnd1B(opnd1B), .opnd2B(opnd2B),
        .memRdA(memRdA), .memRdB(memRdB), .memWeA(memWeA), .memWeB(memWeB),
        .memSrcB(memSrcB), .memAluA(memAluA), .memAluB(memAluB), .memProdB(memProdB)
    );

    wbStage i_wbStage (
        .clk(clk), .arstN(arstN),
        .memRdA(memRdA), .memRdB(memRdB), .memWeA(memWeA), .memWeB(memWeB),
        .memSrcB(memSrcB), .memAluA(memAluA), .memAluB(memAluB), .memProdB(memProdB),
        .wbRdA(wbAddrA), .wbRdB(wbAddrB), .wbWeA(wbWeA), .wbWeB(wbWeB),
        .wbDataA(wbDataA), .wbDataB(wbDataB)
    );

endmodule

`default_nettype wire

//--- test/tbDualIssueExec.sv
`timescale 1ns/1ns
`default_nettype none

`include "dualIssue_settings.svh"

module tbDualIssueExec import dualIssuePkg::*; ();

    localparam int NUM_PAIRS = 400;
    localparam int CLK_PERIOD = 20;
    localparam int WATCHDOG_NS = (NUM_PAIRS + 20) * CLK_PERIOD * 2;
    localparam int WB_LAG = 3;   // Drive slots between issue and check

    typedef struct packed {
        logic weA;
        regAddr rdA;
        dataWord dataA;
        logic weB;
        regAddr rdB;
        dataWord dataB;
    } wbRecord;

    logic clk;
    logic arstN;
    logic issueValid;
    aluOp opA, opB;
    regAddr rs1A, rs2A, rdA, rs1B, rs2B, rdB;
    logic weA, weB;
    logic [`IMM_W-1:0] immA, immB;
    logic wbWeA, wbWeB;
    regAddr wbAddrA, wbAddrB;
    dataWord wbDataA, wbDataB;

    logic [15:0] lfsrState;
    dataWord modelRegs [`NUM_REGS];   // Architectural state
    wbRecord expQ [$];
    regAddr mulDest;   // Product target of the previous pair
    logic mulDestValid;
    int issued;

    dualIssueExec i_dualIssueExec (
        .clk(clk), .arstN(arstN), .issueValid(issueValid),
        .opA(opA), .rs1A(rs1A), .rs2A(rs2A), .rdA(rdA), .weA(weA), .immA(immA),
        .opB(opB), .rs1B(rs1B), .rs2B(rs2B), .rdB(rdB), .weB(weB), .immB(immB),
        .wbWeA(wbWeA), .wbAddrA(wbAddrA), .wbDataA(wbDataA),
        .wbWeB(wbWeB), .wbAddrB(wbAddrB), .wbDataB(wbDataB)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stopRun();
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic checkWord(input string name, input dataWord got, input dataWord exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            stopRun();
        end
    endtask

    task automatic checkAddr(input string name, input regAddr got, input regAddr exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
            stopRun();
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
            stopRun();
        end
    endtask

    // Taps 16,14,13,11
    function automatic logic lfsrBit();
        logic fb;
        fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
        lfsrState = {lfsrState[14:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] randBits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsrBit()};
        end
        return v;
    endfunction

    // Small register window so dependences are frequent
    function automatic regAddr randReg();
        logic [15:0] r;
        r = randBits(3);
        return {2'b00, r[2:0]};
    endfunction

    function automatic regAddr pickSource(input regAddr avoid1, input logic use1,
                                          input regAddr avoid2, input logic use2);
        regAddr r;
        logic ok;
        r = '0;
        ok = 1'b0;
        for (int t = 0; t < 8 && !ok; t++) begin
            r = randReg();
            ok = !((use1 && r == avoid1) || (use2 && r == avoid2));
        end
        if (!ok) r = '0;   // x0 is always safe to read
        return r;
    endfunction

    function automatic dataWord aluModel(input aluOp op, input dataWord a, input dataWord b,
                                         input logic [`IMM_W-1:0] imm);
        dataWord res;
        case (op)
            opAdd:   res = a + b;
            opSub:   res = a - b;
            opAnd:   res = a & b;
            opOr:    res = a | b;
            opXor:   res = a ^ b;
            opSll:   res = a << b[4:0];
            opSrl:   res = a >> b[4:0];
            opAddi:  res = a + dataWord'($signed(imm));
            opMul:   res = a * b;   // Low word only
            default: res = '0;
        endcase
        return res;
    endfunction

    task automatic checkOutputs();
        wbRecord exp;
        exp = expQ.pop_front();
        checkFlag("wbWeA", wbWeA, exp.weA);
        checkFlag("wbWeB", wbWeB, exp.weB);
        if (exp.weA) begin
            checkAddr("wbAddrA", wbAddrA, exp.rdA);
            checkWord("wbDataA", wbDataA, exp.dataA);
        end
        if (exp.weB) begin
            checkAddr("wbAddrB", wbAddrB, exp.rdB);
            checkWord("wbDataB", wbDataB, exp.dataB);
        end
    endtask

    task automatic drivePair(input logic valid);
        aluOp nOpA, nOpB;
        regAddr nRs1A, nRs2A, nRdA, nRs1B, nRs2B, nRdB;
        logic nWeA, nWeB, effA, effB;
        logic [`IMM_W-1:0] nImmA, nImmB;
        logic [15:0] r;
        wbRecord exp;
        r = randBits(3);
        nOpA = aluOp'({1'b0, r[2:0]});
        r = randBits(3);
        nOpB = aluOp'({1'b0, r[2:0]});
        r = randBits(2);
        if (r[1:0] == 2'b11) nOpB = opMul;   // Slot B only
        nRdA = randReg();
        r = randBits(2);
        nWeA = (r[1:0] != 2'b00);
        effA = valid && nWeA && (nRdA != '0);
        nRs1A = pickSource(mulDest, mulDestValid, '0, 1'b0);
        nRs2A = pickSource(mulDest, mulDestValid, '0, 1'b0);
        nRdB = randReg();
        r = randBits(2);
        nWeB = (r[1:0] != 2'b00);
        effB = valid && nWeB && (nRdB != '0);
        nRs1B = pickSource(nRdA, effA, mulDest, mulDestValid);
        nRs2B = pickSource(nRdA, effA, mulDest, mulDestValid);
        r = randBits(12);
        nImmA = r[11:0];
        r = randBits(12);
        nImmB = r[11:0];

        // In-order model, A then B
        exp.weA = effA;
        exp.rdA = nRdA;
        exp.dataA = aluModel(nOpA, modelRegs[nRs1A], modelRegs[nRs2A], nImmA);
        exp.weB = effB;
        exp.rdB = nRdB;
        exp.dataB = aluModel(nOpB, modelRegs[nRs1B], modelRegs[nRs2B], nImmB);
        if (effA) modelRegs[nRdA] = exp.dataA;
        if (effB) modelRegs[nRdB] = exp.dataB;
        mulDestValid = effB && (nOpB == opMul);
        mulDest = nRdB;
        expQ.push_back(exp);

        issueValid = valid;
        opA = nOpA;
        rs1A = nRs1A;
        rs2A = nRs2A;
        rdA = nRdA;
        weA = nWeA;
        immA = nImmA;
        opB = nOpB;
        rs1B = nRs1B;
        rs2B = nRs2B;
        rdB = nRdB;
        weB = nWeB;
        immB = nImmB;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the pipeline run did not finish within %0d ns", WATCHDOG_NS);
        stopRun();
    end

    initial begin
        logic [15:0] r;
        clk = 1'b0;
        arstN = 1'b0;
        issueValid = 1'b0;
        opA = opAdd;
        opB = opAdd;
        {rs1A, rs2A, rdA, rs1B, rs2B, rdB} = '0;
        {weA, weB} = '0;
        immA = '0;
        immB = '0;
        lfsrState = 16'd65;
        mulDest = '0;
        mulDestValid = 1'b0;
        issued = 0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < WB_LAG; i++) begin
            expQ.push_back('0);   // Pipeline is empty after reset
        end

        repeat (10) @(posedge clk);
        #2 arstN = 1'b1;

        while (issued < NUM_PAIRS) begin
            @(posedge clk);
            #2;
            checkOutputs();
            r = randBits(3);
            if (r[2:0] == 3'b000) begin
                drivePair(1'b0);   // Idle cycle
            end else begin
                drivePair(1'b1);
                issued++;
            end
        end
        repeat (WB_LAG) begin
            @(posedge clk);
            #2;
            checkOutputs();
            drivePair(1'b0);
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- dualIssueExec.f
+incdir+hw
hw/dualIssuePkg.sv
hw/regFile.sv
hw/exLatch.sv
hw/forwardUnit.sv
hw/aluUnit.sv
hw/memStage.sv
hw/wbStage.sv
hw/dualIssueExec.sv
test/tbDualIssueExec.sv

//--- run.sh
#!/bin/sh
# Build and run the dual-issue execute pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns \
    --top-module tbDualIssueExec -f dualIssueExec.f -o simDualIssue

./obj_dir/simDualIssue | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation ended without a pass report"
    exit 1
fi
echo "Simulation finished cleanly"
